// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := TbMonopix
FILELIST  := filelist.f
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := test failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIMBIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIMBIN)
	@./$(SIMBIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: filelist.f
+incdir+include
source/MonopixConfPkg.sv
source/MonopixTimingPkg.sv
source/ConfigRegister.sv
source/BcidGenerator.sv
source/MatrixPeriphery.sv
source/MonopixDigital.sv
verif/MonopixChecker.sv
verif/TbMonopix.sv

// File: include/monopix_params.svh
`ifndef MONOPIX_PARAMS_SVH
`define MONOPIX_PARAMS_SVH

`define NUM_FLAVORS 4        // PMOS no SF, PMOS, COMP, HV
`define MATRIX_COLS 16       // Injection columns
`define MON_LINES   4        // Digital monitor lines per flavor
`define BCID_BITS   6
`define CONF_BITS   42

// Global configuration layout, LSB first
`define CONF_EN_HITOR_LSB    0   // Active low, true hit-or pads
`define CONF_NEN_HITOR_LSB   4   // Active low, complementary hit-or pads
`define CONF_COL_PULSE_LSB   8   // Column injection select
`define CONF_INJ_MON_L       24
`define CONF_INJ_MON_R       25
// Flavor f owns bits f*MON_LINES up to f*MON_LINES+MON_LINES-1 of this field
`define CONF_DIG_MON_SEL_LSB 26

`endif

// File: source/BcidGenerator.sv
`timescale 1ns/1ns
`include "monopix_params.svh"

module BcidGenerator (
    input  logic                   ClkBx,
    input  logic                   reset_ff,
    input  logic                   ResetBcid,   // Synchronous counter clear
    output MonopixTimingPkg::tBcid Bcid
);
    import MonopixTimingPkg::*;

    logic resetBcidQ;
    tBcid binCnt;

    // One register stage on the BCID reset line
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            resetBcidQ <= 1'b0;
        end else begin
            resetBcidQ <= ResetBcid;
        end
    end

    // Free running, wraps at 2**BCID_BITS
    always_ff @(posedge ClkBx) begin
        if (reset_ff || resetBcidQ) begin
            binCnt <= '0;
        end else begin
            binCnt <= binCnt + 1'b1;
        end
    end

    // Gray code so the matrix never samples a multi-bit transition
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            Bcid <= '0;
        end else begin
            Bcid <= binCnt ^ (binCnt >> 1);
        end
    end

    // Undisturbed counting moves the published code by a single bit
    assert property (@(posedge ClkBx) disable iff (reset_ff)
        (!$past(resetBcidQ, 1) && !$past(resetBcidQ, 2) &&
         !$past(reset_ff, 1) && !$past(reset_ff, 2))
        |-> $onehot(Bcid ^ $past(Bcid)));

endmodule

// File: source/ConfigRegister.sv
`timescale 1ns/1ns
`include "monopix_params.svh"

module ConfigRegister (
    input  logic                     ClkBx,
    input  logic                     reset_ff,
    input  logic                     ShiftEn,   // One bit per cycle while high
    input  logic                     SiConf,
    input  logic                     LdConf,
    input  logic                     DefConf,   // Forces the default word
    output logic                     SoConf,
    output MonopixConfPkg::tConfWord Conf
);
    import MonopixConfPkg::*;

    tConfWord shiftReg;
    tConfWord confLatch;

    // Serial chain
    // New bit enters at the LSB, the oldest bit leaves at the MSB, so a word
    // goes in MSB first and the held word reads back MSB first.
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            shiftReg <= DEFAULT_CONF;
        end else if (ShiftEn) begin
            shiftReg <= {shiftReg[`CONF_BITS-2:0], SiConf};
        end
    end

    // Latch takes the chain as it was before this edge
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            confLatch <= DEFAULT_CONF;
        end else if (LdConf) begin
            confLatch <= shiftReg;
        end
    end

    assign SoConf = shiftReg[`CONF_BITS-1];  // Straight from a flop

    // Default override acts without a clock edge
    assign Conf = DefConf ? DEFAULT_CONF : confLatch;

    // Load path, chain contents show up on Conf one edge later
    assert property (@(posedge ClkBx) disable iff (reset_ff)
        ($past(LdConf) && !$past(reset_ff) && !DefConf) |-> (Conf == $past(shiftReg)));

endmodule

// File: source/MatrixPeriphery.sv
`timescale 1ns/1ns
`include "monopix_params.svh"

module MatrixPeriphery (
    input  logic                       ClkBx,
    input  logic                       reset_ff,
    input  logic                       Pulse,      // Injection strobe
    input  MonopixTimingPkg::tMonLines DigMon,
    input  MonopixConfPkg::tConfWord   Conf,
    output MonopixConfPkg::tColMask    InjIn,
    output logic                       InjMonL,
    output logic                       InjMonR,
    output MonopixConfPkg::tFlavorMask HitOrPad,
    output MonopixConfPkg::tFlavorMask HitOrNPad
);
    import MonopixConfPkg::*;
    import MonopixTimingPkg::*;

    tFlavorMask enHitOr;    // Active low
    tFlavorMask nEnHitOr;   // Active low
    tColMask    colPulseSel;
    logic       injMonLSel;
    logic       injMonRSel;
    tMonSel     digMonSel;
    tFlavorMask hitOr;

    // Configuration fields
    assign enHitOr     = Conf[`CONF_EN_HITOR_LSB +: `NUM_FLAVORS];
    assign nEnHitOr    = Conf[`CONF_NEN_HITOR_LSB +: `NUM_FLAVORS];
    assign colPulseSel = Conf[`CONF_COL_PULSE_LSB +: `MATRIX_COLS];
    assign injMonLSel  = Conf[`CONF_INJ_MON_L];
    assign injMonRSel  = Conf[`CONF_INJ_MON_R];
    assign digMonSel   = Conf[`CONF_DIG_MON_SEL_LSB +: `NUM_FLAVORS*`MON_LINES];

    // Selected monitor lines of each flavor reduced to one hit-or
    always_comb begin
        for (int f = 0; f < `NUM_FLAVORS; f++) begin
            hitOr[f] = |(DigMon[f*`MON_LINES +: `MON_LINES] &
                         digMonSel[f*`MON_LINES +: `MON_LINES]);
        end
    end

    // Injection gating
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            InjIn   <= '0;
            InjMonL <= 1'b0;
            InjMonR <= 1'b0;
        end else begin
            InjIn   <= {`MATRIX_COLS{Pulse}} & colPulseSel;
            InjMonL <= Pulse & injMonLSel;  // Left monitor pixel
            InjMonR <= Pulse & injMonRSel;  // Right monitor pixel
        end
    end

    // Pad drivers, a disabled pad reads as 0
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            HitOrPad  <= '0;
            HitOrNPad <= '0;
        end else begin
            HitOrPad  <= hitOr & ~enHitOr;
            HitOrNPad <= ~hitOr & ~nEnHitOr;  // Complementary pad
        end
    end

    // A pad pair never shows the same high level
    assert property (@(posedge ClkBx) disable iff (reset_ff)
        (HitOrPad & HitOrNPad) == '0);

endmodule

// File: source/MonopixConfPkg.sv
`include "monopix_params.svh"

package MonopixConfPkg;

    // Whole global configuration word as it sits in the latch
    typedef logic [`CONF_BITS-1:0] tConfWord;

    // One bit per flavor, used by both hit-or pad enables
    typedef logic [`NUM_FLAVORS-1:0] tFlavorMask;

    // One bit per injection column
    typedef logic [`MATRIX_COLS-1:0] tColMask;

    // One bit per digital monitor line, flavor-major
    typedef logic [`NUM_FLAVORS*`MON_LINES-1:0] tMonSel;

    // Power-up configuration
    // Both hit-or pad enables are active low, so all ones keeps the pads quiet.
    // Injection and monitor selection start cleared.
    localparam tConfWord DEFAULT_CONF =
        (tConfWord'({`NUM_FLAVORS{1'b1}}) << `CONF_EN_HITOR_LSB) |
        (tConfWord'({`NUM_FLAVORS{1'b1}}) << `CONF_NEN_HITOR_LSB);

endpackage

// File: source/MonopixDigital.sv
`timescale 1ns/1ns

module MonopixDigital (
    input  logic                       ClkBx,
    input  logic                       reset_ff,
    input  logic                       ShiftEn,
    input  logic                       SiConf,
    input  logic                       LdConf,
    input  logic                       DefConf,
    input  logic                       ResetBcid,
    input  logic                       Pulse,
    input  MonopixTimingPkg::tMonLines DigMon,
    output logic                       SoConf,
    output MonopixTimingPkg::tBcid     Bcid,
    output MonopixConfPkg::tColMask    InjIn,
    output logic                       InjMonL,
    output logic                       InjMonR,
    output MonopixConfPkg::tFlavorMask HitOrPad,
    output MonopixConfPkg::tFlavorMask HitOrNPad
);
    import MonopixConfPkg::*;

    tConfWord conf;  // Active global configuration

    ConfigRegister ConfigRegister_i (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .ShiftEn  (ShiftEn),
        .SiConf   (SiConf),
        .LdConf   (LdConf),
        .DefConf  (DefConf),
        .SoConf   (SoConf),
        .Conf     (conf)
    );

    // Counter runs on its own, no configuration involved
    BcidGenerator BcidGenerator_i (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ResetBcid (ResetBcid),
        .Bcid      (Bcid)
    );

    MatrixPeriphery MatrixPeriphery_i (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .Pulse     (Pulse),
        .DigMon    (DigMon),
        .Conf      (conf),
        .InjIn     (InjIn),
        .InjMonL   (InjMonL),
        .InjMonR   (InjMonR),
        .HitOrPad  (HitOrPad),
        .HitOrNPad (HitOrNPad)
    );

endmodule

// File: source/MonopixTimingPkg.sv
`include "monopix_params.svh"

package MonopixTimingPkg;

    // Bunch-crossing count, binary inside the counter, Gray on the output
    typedef logic [`BCID_BITS-1:0] tBcid;

    // Raw digital monitor levels coming from the matrix, flavor-major
    typedef logic [`NUM_FLAVORS*`MON_LINES-1:0] tMonLines;

endpackage

// File: verif/MonopixChecker.sv
`timescale 1ns/1ns
`include "monopix_params.svh"

module MonopixChecker (
    input  logic                       ClkBx,
    input  logic                       reset_ff,
    input  logic                       ShiftEn,
    input  logic                       SiConf,
    input  logic                       LdConf,
    input  logic                       DefConf,
    input  logic                       ResetBcid,
    input  logic                       Pulse,
    input  MonopixTimingPkg::tMonLines DigMon,
    input  logic                       SoConf,
    input  MonopixTimingPkg::tBcid     Bcid,
    input  MonopixConfPkg::tColMask    InjIn,
    input  logic                       InjMonL,
    input  logic                       InjMonR,
    input  MonopixConfPkg::tFlavorMask HitOrPad,
    input  MonopixConfPkg::tFlavorMask HitOrNPad,
    input  logic [2:0]                 Phase,        // Current test step
    input  logic                       ClearSeen,    // Restart the Bcid coverage
    output int                         ErrorCount,
    output int                         CheckCount,
    output logic                       SeenAllBcid
);
    import MonopixConfPkg::*;
    import MonopixTimingPkg::*;

    tConfWord   defaultWord;
    tConfWord   activeConf;
    tConfWord   mdlShift;
    tConfWord   mdlLatch;
    logic       mdlResetQ;
    tBcid       mdlCount;
    tBcid       mdlBcid;
    tColMask    mdlInjIn;
    logic       mdlInjMonL;
    logic       mdlInjMonR;
    tFlavorMask mdlHitOrPad;
    tFlavorMask mdlHitOrNPad;
    tFlavorMask expHit;
    logic       modelValid;
    logic [(1 << `BCID_BITS)-1:0] seenBcid;

    // Only the two pad enable fields are set at power-up
    function automatic tConfWord buildDefault();
        tConfWord w;
        w = '0;
        for (int f = 0; f < `NUM_FLAVORS; f++) begin
            w[`CONF_EN_HITOR_LSB + f]  = 1'b1;
            w[`CONF_NEN_HITOR_LSB + f] = 1'b1;
        end
        return w;
    endfunction

    function automatic tFlavorMask maskedHitOr(input tMonLines lines, input tConfWord conf);
        tFlavorMask h;
        for (int f = 0; f < `NUM_FLAVORS; f++) begin
            h[f] = 1'b0;
            for (int m = 0; m < `MON_LINES; m++) begin
                if (lines[f*`MON_LINES + m] && conf[`CONF_DIG_MON_SEL_LSB + f*`MON_LINES + m])
                    h[f] = 1'b1;
            end
        end
        return h;
    endfunction

    function automatic tBcid grayOf(input tBcid bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic string phaseName(input logic [2:0] p);
        case (p)
            3'd0:    return "reset";
            3'd1:    return "defaults";
            3'd2:    return "config_load";
            3'd3:    return "readback";
            3'd4:    return "injection";
            3'd5:    return "hit_or";
            default: return "bcid";
        endcase
    endfunction

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        CheckCount++;
        if (actual !== expected) begin
            ErrorCount++;
            $display("Error %s %s expected %h actual %h at %0t",
                     phaseName(Phase), what, expected, actual, $time);
        end
    endtask

    assign defaultWord = buildDefault();
    assign activeConf  = DefConf ? defaultWord : mdlLatch;  // Override without a clock
    assign expHit      = maskedHitOr(DigMon, activeConf);
    assign SeenAllBcid = &seenBcid;

    initial begin
        ErrorCount = 0;
        CheckCount = 0;
        modelValid = 1'b0;
        seenBcid   = '0;
    end

    // Cycle model, inputs as they were before the edge
    always @(posedge ClkBx) begin
        if (reset_ff) begin
            modelValid   <= 1'b1;
            mdlShift     <= defaultWord;
            mdlLatch     <= defaultWord;
            mdlResetQ    <= 1'b0;
            mdlCount     <= '0;
            mdlBcid      <= '0;
            mdlInjIn     <= '0;
            mdlInjMonL   <= 1'b0;
            mdlInjMonR   <= 1'b0;
            mdlHitOrPad  <= '0;
            mdlHitOrNPad <= '0;
        end else begin
            if (ShiftEn)
                mdlShift <= {mdlShift[`CONF_BITS-2:0], SiConf};
            if (LdConf)
                mdlLatch <= mdlShift;  // Old chain contents
            mdlResetQ <= ResetBcid;
            mdlCount  <= mdlResetQ ? tBcid'(0) : mdlCount + tBcid'(1);
            mdlBcid   <= grayOf(mdlCount);
            for (int c = 0; c < `MATRIX_COLS; c++)
                mdlInjIn[c] <= Pulse && activeConf[`CONF_COL_PULSE_LSB + c];
            mdlInjMonL <= Pulse && activeConf[`CONF_INJ_MON_L];
            mdlInjMonR <= Pulse && activeConf[`CONF_INJ_MON_R];
            for (int f = 0; f < `NUM_FLAVORS; f++) begin
                mdlHitOrPad[f]  <= expHit[f] && !activeConf[`CONF_EN_HITOR_LSB + f];
                mdlHitOrNPad[f] <= !expHit[f] && !activeConf[`CONF_NEN_HITOR_LSB + f];
            end
        end
    end

    // Outputs are settled half a period after the edge
    always @(negedge ClkBx) begin
        if (modelValid) begin
            compare("SoConf", 64'(mdlShift[`CONF_BITS-1]), 64'(SoConf));
            compare("Bcid", 64'(mdlBcid), 64'(Bcid));
            compare("InjIn", 64'(mdlInjIn), 64'(InjIn));
            compare("InjMonL", 64'(mdlInjMonL), 64'(InjMonL));
            compare("InjMonR", 64'(mdlInjMonR), 64'(InjMonR));
            compare("HitOrPad", 64'(mdlHitOrPad), 64'(HitOrPad));
            compare("HitOrNPad", 64'(mdlHitOrNPad), 64'(HitOrNPad));
        end
        if (ClearSeen)
            seenBcid = '0;
        else if (modelValid && !reset_ff && !$isunknown(Bcid))
            seenBcid[Bcid] = 1'b1;
    end

endmodule

// File: verif/TbMonopix.sv
`timescale 1ns/1ns
`include "monopix_params.svh"

module TbMonopix;
    import MonopixConfPkg::*;
    import MonopixTimingPkg::*;

    localparam logic [31:0] LCG_MUL       = 32'd1103515245;
    localparam logic [31:0] LCG_INC       = 32'd12345;
    localparam int          RESET_CYCLES  = 10;
    localparam int          WRAP_TIMEOUT  = 300;  // Cycles to see every Bcid value
    localparam int          CLEAR_TIMEOUT = 6;    // Cycles from ResetBcid to Bcid zero

    logic        ClkBx;
    logic        reset_ff;
    logic        ShiftEn;
    logic        SiConf;
    logic        LdConf;
    logic        DefConf;
    logic        ResetBcid;
    logic        Pulse;
    tMonLines    DigMon;
    logic        SoConf;
    tBcid        Bcid;
    tColMask     InjIn;
    logic        InjMonL;
    logic        InjMonR;
    tFlavorMask  HitOrPad;
    tFlavorMask  HitOrNPad;
    logic [2:0]  phase;
    logic        clearSeen;
    logic        seenAllBcid;
    logic [31:0] lcgState;
    int          errorCount;
    int          checkCount;
    int          timeoutCount;

    function automatic logic [15:0] nextRandom();
        lcgState = lcgState * LCG_MUL + LCG_INC;
        return lcgState[31:16];  // Upper half since low LCG bits repeat quickly
    endfunction

    function automatic logic [31:0] randomBits();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = nextRandom();
        lo = nextRandom();
        return {hi, lo};
    endfunction

    function automatic tConfWord randomConf();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = randomBits();
        lo = randomBits();
        return tConfWord'({hi, lo});
    endfunction

    // Sparse monitor hits of about one line in four
    task automatic driveRandomInputs();
        logic [31:0] r;
        logic [31:0] s;
        r = randomBits();
        s = randomBits();
        Pulse  <= s[7];
        DigMon <= tMonLines'(r[15:0] & r[31:16]);
    endtask

    task automatic driveTraffic(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge ClkBx);
            driveRandomInputs();
        end
    endtask

    // MSB first and then an optional load strobe
    task automatic shiftWord(input tConfWord word, input logic load);
        for (int i = `CONF_BITS-1; i >= 0; i--) begin
            @(posedge ClkBx);
            ShiftEn <= 1'b1;
            SiConf  <= word[i];
            driveRandomInputs();
        end
        @(posedge ClkBx);
        ShiftEn <= 1'b0;
        LdConf  <= load;
        @(posedge ClkBx);
        LdConf  <= 1'b0;
    endtask

    task automatic waitAllBcid();
        int waited;
        waited = 0;
        while (!seenAllBcid && waited < WRAP_TIMEOUT) begin
            @(negedge ClkBx);
            waited++;
        end
        if (!seenAllBcid) begin
            $display("Timeout: Bcid did not pass through all values within %0d cycles",
                     WRAP_TIMEOUT);
            timeoutCount++;
        end
    endtask

    task automatic waitBcidZero();
        int waited;
        waited = 0;
        do begin
            @(negedge ClkBx);
            waited++;
        end while (Bcid !== '0 && waited < CLEAR_TIMEOUT);
        if (Bcid !== '0) begin
            $display("Timeout: Bcid did not return to zero after ResetBcid");
            timeoutCount++;
        end
    endtask

    task automatic finishRun();
        $display("Checks: %0d  errors: %0d  timeouts: %0d",
                 checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0 && checkCount > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    initial begin
        ClkBx = 1'b0;
        forever #5 ClkBx = ~ClkBx;
    end

    MonopixDigital MonopixDigital_i (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ShiftEn   (ShiftEn),
        .SiConf    (SiConf),
        .LdConf    (LdConf),
        .DefConf   (DefConf),
        .ResetBcid (ResetBcid),
        .Pulse     (Pulse),
        .DigMon    (DigMon),
        .SoConf    (SoConf),
        .Bcid      (Bcid),
        .InjIn     (InjIn),
        .InjMonL   (InjMonL),
        .InjMonR   (InjMonR),
        .HitOrPad  (HitOrPad),
        .HitOrNPad (HitOrNPad)
    );

    MonopixChecker MonopixChecker_i (
        .ClkBx       (ClkBx),
        .reset_ff    (reset_ff),
        .ShiftEn     (ShiftEn),
        .SiConf      (SiConf),
        .LdConf      (LdConf),
        .DefConf     (DefConf),
        .ResetBcid   (ResetBcid),
        .Pulse       (Pulse),
        .DigMon      (DigMon),
        .SoConf      (SoConf),
        .Bcid        (Bcid),
        .InjIn       (InjIn),
        .InjMonL     (InjMonL),
        .InjMonR     (InjMonR),
        .HitOrPad    (HitOrPad),
        .HitOrNPad   (HitOrNPad),
        .Phase       (phase),
        .ClearSeen   (clearSeen),
        .ErrorCount  (errorCount),
        .CheckCount  (checkCount),
        .SeenAllBcid (seenAllBcid)
    );

    initial begin
        logic [31:0] r;
        lcgState     = 32'd11101;
        timeoutCount = 0;
        reset_ff     = 1'b1;
        ShiftEn      = 1'b0;
        SiConf       = 1'b0;
        LdConf       = 1'b0;
        DefConf      = 1'b0;
        ResetBcid    = 1'b0;
        Pulse        = 1'b0;
        DigMon       = '0;
        phase        = 3'd0;
        clearSeen    = 1'b0;

        repeat (RESET_CYCLES) @(posedge ClkBx);
        reset_ff <= 1'b0;
        phase    <= 3'd1;
        driveTraffic(30);  // Default word keeps both pads quiet

        phase <= 3'd2;
        shiftWord(randomConf(), 1'b1);
        driveTraffic(30);
        @(posedge ClkBx);
        DefConf <= 1'b1;
        driveTraffic(20);
        @(posedge ClkBx);
        DefConf <= 1'b0;
        driveTraffic(20);

        phase <= 3'd3;
        shiftWord(randomConf(), 1'b0);  // SoConf replays the held word
        shiftWord(randomConf(), 1'b1);

        phase <= 3'd4;
        for (int n = 0; n < 6; n++) begin
            shiftWord(randomConf(), 1'b1);
            driveTraffic(25);
        end

        phase <= 3'd5;
        for (int n = 0; n < 6; n++) begin
            shiftWord(randomConf(), 1'b1);
            driveTraffic(25);
        end

        phase <= 3'd6;
        @(posedge ClkBx);
        clearSeen <= 1'b1;
        @(posedge ClkBx);
        clearSeen <= 1'b0;
        waitAllBcid();
        for (int n = 0; n < 5; n++) begin
            r = randomBits();
            driveTraffic(3 + int'(r[5:0]));
            @(posedge ClkBx);
            ResetBcid <= 1'b1;
            @(posedge ClkBx);
            ResetBcid <= 1'b0;
            waitBcidZero();
            driveTraffic(8);  // Gray 1, 3, 2 and onward
        end

        repeat (3) @(posedge ClkBx);
        @(negedge ClkBx);
        finishRun();
    end

endmodule
